// ==== Makefile ====
# Verilator flow for the phase interpolator

TOP = phase_interpolator_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f phase_interpolator.f --top-module $(TOP)
	verilator --lint-only --timing -f phase_interpolator.f --top-module phase_interpolator

sim:
	verilator --binary --timing -f phase_interpolator.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== phase_interpolator.f ====
src/pi_timing_pkg.sv
src/pi_code_pkg.sv
src/phase_pair_if.sv
src/pi_input_stage.sv
src/phase_blender_1b.sv
src/pi_blend_tree.sv
src/pi_output_stage.sv
src/phase_interpolator.sv
testbench/phase_interpolator_tb.sv

// ==== src/phase_blender_1b.sv ====
//********************
// Behavioural 1-bit phase blender.
// Passes the leading edge or the mid-point of two clocks,
// each delayed by a fixed blend delay.
//********************

`timescale 1ns/1ps
`default_nettype none

module phase_blender_1b #(
    parameter int blend_delay_ps = 50
) (
    input  wire logic [1:0] ph_in,    // element 0 leads
    input  wire logic       en_mixer, // 1 blends, 0 passes the first edge
    output logic            ph_out
);

    // intrinsic delay in timescale units
    localparam real td_ns = real'(blend_delay_ps) / 1000.0;

    // share of the measured spacing added to the delay
    real wgt;

    // last edge times per input, negative until seen
    real rise_t [2] = '{-1.0, -1.0};
    real fall_t [2] = '{-1.0, -1.0};
    real t_now;

    logic [1:0] ph_prev    = 2'b00;
    logic [1:0] rose;
    logic [1:0] fell;
    logic       level_next = 1'b0;
    logic       out_q      = 1'b0;

    assign wgt    = en_mixer ? 0.5 : 0.0;
    assign ph_out = out_q;

    // spacing share when the other input followed this one last time
    function automatic real share(input real t_self, input real t_other, input real w);
        if (t_self >= 0.0 && t_other >= 0.0 && t_other >= t_self) begin
            return w * (t_other - t_self);
        end
        return 0.0;
    endfunction

    // first edge of a new level schedules the output
    task automatic take_edge(input logic lvl, input real share_ns);
        if (lvl != level_next) begin
            level_next = lvl;
            out_q <= #(td_ns + share_ns) lvl;
        end
    endtask

    always @(ph_in) begin
        t_now = $realtime;
        rose  = {ph_in[1] === 1'b1 && ph_prev[1] !== 1'b1,
                 ph_in[0] === 1'b1 && ph_prev[0] !== 1'b1};
        fell  = {ph_in[1] === 1'b0 && ph_prev[1] !== 1'b0,
                 ph_in[0] === 1'b0 && ph_prev[0] !== 1'b0};

        // leading input first, so equal inputs act as a bypass
        if (rose[0]) begin
            take_edge(1'b1, share(rise_t[0], rise_t[1], wgt));
            rise_t[0] = t_now;
        end
        if (fell[0]) begin
            take_edge(1'b0, share(fall_t[0], fall_t[1], wgt));
            fall_t[0] = t_now;
        end
        if (rose[1]) begin
            take_edge(1'b1, share(rise_t[1], rise_t[0], 1.0 - wgt));
            rise_t[1] = t_now;
        end
        if (fell[1]) begin
            take_edge(1'b0, share(fall_t[1], fall_t[0], 1.0 - wgt));
            fall_t[1] = t_now;
        end
        ph_prev = ph_in;
    end

endmodule

`default_nettype wire

// ==== src/phase_interpolator.sv ====
//********************
// Four-phase clock phase interpolator, top level.
// Load a 4-bit code with code_load, wait for settled.
//********************

`timescale 1ns/1ps
`default_nettype none

module phase_interpolator #(
    parameter int blend_delay_ps = 50
) (
    input  wire logic [pi_timing_pkg::n_phases-1:0] ph_in,     // quadrature clocks
    input  wire logic                               arst_n,
    input  wire logic [3:0]                         pi_code,
    input  wire logic                               code_load,
    output logic                                    ph_out,    // interpolated clock
    output logic                                    settled    // ph_out carries the new phase
);

    phase_pair_if pair ();

    logic ph_blend;

    pi_input_stage u_input (
        .ph_in     (ph_in),
        .arst_n    (arst_n),
        .pi_code   (pi_code),
        .code_load (code_load),
        .pair      (pair.source)
    );

    pi_blend_tree #(.blend_delay_ps(blend_delay_ps)) u_blend (
        .pair     (pair.blend),
        .ph_blend (ph_blend)
    );

    pi_output_stage u_output (
        .ph_in    (ph_in),
        .arst_n   (arst_n),
        .pair     (pair.watch),
        .ph_blend (ph_blend),
        .ph_out   (ph_out),
        .settled  (settled)
    );

endmodule

`default_nettype wire

// ==== src/phase_pair_if.sv ====
//********************
// Selected clock pair and step, from the input stage
// to the blend tree and the output stage.
//********************

`timescale 1ns/1ps
`default_nettype none

interface phase_pair_if;

    // leading and lagging clock of the selected quadrant
    logic lead;
    logic lag;

    // step inside the quadrant
    pi_code_pkg::step_t step;

    // one ph_in[0] cycle high after each code load
    logic code_change;

    modport source (
        output lead,
        output lag,
        output step,
        output code_change
    );

    modport blend (
        input lead,
        input lag,
        input step
    );

    modport watch (
        input code_change,
        input lead
    );

endinterface

`default_nettype wire

// ==== src/pi_blend_tree.sv ====
//********************
// Two-stage blend tree.
// Turns a clock pair and a step into one of four phases.
//********************

`timescale 1ns/1ps
`default_nettype none

module pi_blend_tree #(
    parameter int blend_delay_ps = 50
) (
    phase_pair_if.blend pair,
    output logic        ph_blend // interpolated clock
);

    // steps below this use the lead..mid half of the quadrant
    localparam int half_steps = pi_timing_pkg::steps_per_quadrant / 2;

    // first stage taps, all with one blend delay
    logic lead_tap;
    logic mid_tap;
    logic lag_tap;

    // second stage inputs
    logic tap_a;
    logic tap_b;
    logic mix_en;

    phase_blender_1b #(.blend_delay_ps(blend_delay_ps)) u_tap_lead (
        .ph_in    ({pair.lead, pair.lead}),
        .en_mixer (1'b0),
        .ph_out   (lead_tap)
    );

    phase_blender_1b #(.blend_delay_ps(blend_delay_ps)) u_tap_mid (
        .ph_in    ({pair.lag, pair.lead}),
        .en_mixer (1'b1),
        .ph_out   (mid_tap)
    );

    phase_blender_1b #(.blend_delay_ps(blend_delay_ps)) u_tap_lag (
        .ph_in    ({pair.lag, pair.lag}),
        .en_mixer (1'b0),
        .ph_out   (lag_tap)
    );

    // odd steps mix two neighbouring taps, even steps pass one tap
    always_comb begin
        if (int'(pair.step) < half_steps) begin
            tap_a = lead_tap;
            tap_b = mid_tap;
        end else begin
            tap_a = mid_tap;
            tap_b = lag_tap;
        end
        mix_en = pair.step[0];
    end

    phase_blender_1b #(.blend_delay_ps(blend_delay_ps)) u_mix (
        .ph_in    ({mix_en ? tap_b : tap_a, tap_a}),
        .en_mixer (mix_en),
        .ph_out   (ph_blend)
    );

endmodule

`default_nettype wire

// ==== src/pi_code_pkg.sv ====
//********************
// Interpolation code types.
// The code word is read raw or as quadrant and step fields.
//********************

`default_nettype none

package pi_code_pkg;

    // index of the leading phase
    typedef logic [1:0] quadrant_t;

    // step inside a quadrant, 0 is the leading phase itself
    typedef logic [1:0] step_t;

    // upper bits pick the quadrant, lower bits the step
    typedef struct packed {
        quadrant_t quadrant;
        step_t     step;
    } pi_fields_t;

    // loaded as a raw word, decoded through fld
    typedef union packed {
        logic [3:0] raw;
        pi_fields_t fld;
    } pi_code_t;

endpackage

`default_nettype wire

// ==== src/pi_input_stage.sv ====
//********************
// Input side of the interpolator.
// Captures the code on a load strobe and selects the clock pair.
//********************

`timescale 1ns/1ps
`default_nettype none

module pi_input_stage (
    input  wire logic [pi_timing_pkg::n_phases-1:0] ph_in,     // quadrature clocks
    input  wire logic                               arst_n,
    input  wire logic [3:0]                         pi_code,   // raw interpolation code
    input  wire logic                               code_load, // load strobe
    phase_pair_if.source                            pair
);

    // current code, decoded into quadrant and step
    pi_code_pkg::pi_code_t code_q;

    // previous strobe level for edge detection
    logic load_q;
    logic load_hit;

    // phase following the leading one, wraps 3 -> 0
    pi_code_pkg::quadrant_t lag_idx;

    // only the first sampled high level of a strobe loads
    assign load_hit = code_load & ~load_q;

    always_ff @(posedge ph_in[0] or negedge arst_n) begin
        if (!arst_n) begin
            code_q.raw       <= '0;
            load_q           <= 1'b0;
            pair.code_change <= 1'b0;
        end else begin
            load_q           <= code_load;
            pair.code_change <= load_hit;
            if (load_hit) begin
                code_q.raw <= pi_code;
            end
        end
    end

    // 2-bit index wraps on its own
    assign lag_idx = pi_code_pkg::quadrant_t'(code_q.fld.quadrant + 2'd1);

    // pair selection follows the code register directly
    assign pair.lead = ph_in[code_q.fld.quadrant];
    assign pair.lag  = ph_in[lag_idx];
    assign pair.step = code_q.fld.step;

endmodule

`default_nettype wire

// ==== src/pi_output_stage.sv ====
//********************
// Output side of the interpolator.
// Settle counter after a code change and a glitch-free output gate.
//********************

`timescale 1ns/1ps
`default_nettype none

module pi_output_stage (
    input  wire logic [pi_timing_pkg::n_phases-1:0] ph_in,    // only phase 0 is used
    input  wire logic                               arst_n,
    phase_pair_if.watch                             pair,
    input  wire logic                               ph_blend, // blended clock
    output logic                                    ph_out,
    output logic                                    settled
);

    localparam int cnt_w = $clog2(pi_timing_pkg::settle_cycles + 1);

    logic [cnt_w-1:0] settle_cnt;

    // lead activity seen from the ph_in[0] side
    logic lead_tgl;
    logic lead_tgl_q;
    logic lead_moved;
    logic lead_seen;

    logic gate_en;

    // flips on every lead rising edge
    always_ff @(posedge pair.lead or negedge arst_n) begin
        if (!arst_n) begin
            lead_tgl <= 1'b0;
        end else begin
            lead_tgl <= ~lead_tgl;
        end
    end

    assign lead_moved = lead_tgl ^ lead_tgl_q;

    // a new code restarts the count, even in the middle of settling
    always_ff @(posedge ph_in[0] or negedge arst_n) begin
        if (!arst_n) begin
            settle_cnt <= '0;
            settled    <= 1'b0;
            lead_seen  <= 1'b0;
            lead_tgl_q <= 1'b0;
        end else begin
            lead_tgl_q <= lead_tgl;
            if (pair.code_change) begin
                settle_cnt <= '0;
                settled    <= 1'b0;
                lead_seen  <= 1'b0;
            end else if (!settled) begin
                lead_seen <= lead_seen | lead_moved;
                if (settle_cnt == cnt_w'(pi_timing_pkg::settle_cycles - 1)) begin
                    // blenders must have had a lead edge with the new code
                    if (lead_seen | lead_moved) begin
                        settled <= 1'b1;
                    end
                end else begin
                    settle_cnt <= settle_cnt + 1'b1;
                end
            end
        end
    end

    // gate moves only while the blended clock is low
    always_ff @(negedge ph_blend or negedge arst_n) begin
        if (!arst_n) begin
            gate_en <= 1'b0;
        end else begin
            gate_en <= settled & ~pair.code_change;
        end
    end

    assign ph_out = ph_blend & gate_en;

endmodule

`default_nettype wire

// ==== src/pi_timing_pkg.sv ====
//********************
// Timing constants of the phase interpolator model.
// Shared by the RTL and the testbench through scoped names.
//********************

`default_nettype none

package pi_timing_pkg;

    // quadrature clock phases on ph_in
    localparam int n_phases = 4;

    // interpolation steps between two adjacent phases
    // with a 100 ns period this gives 6.25 ns per step
    localparam int steps_per_quadrant = 4;

    // ph_in[0] rising edges after a code change before
    // the output gate opens again
    localparam int settle_cycles = 4;

endpackage

`default_nettype wire

// ==== testbench/phase_interpolator_golden.txt ====
# code (hex, quadrant in upper bits, step in lower bits)
# expected ph_out offset from the ph_in[0] rising edge in ns, 50 ps blend delay
0 0.100
1 6.350
2 12.600
3 18.850
4 25.100
5 31.350
6 37.600
7 43.850
8 50.100
9 56.350
a 62.600
b 68.850
c 75.100
d 81.350
e 87.600
f 93.850

// ==== testbench/phase_interpolator_tb.sv ====
//********************
// Testbench for the phase interpolator.
// Replays the golden cases and checks settling and edge times.
//********************

`timescale 1ns/1ps
`default_nettype none

module phase_interpolator_tb;

    logic [pi_timing_pkg::n_phases-1:0] ph_in = '0;
    logic       arst_n    = 1'b0;
    logic [3:0] pi_code   = 4'h0;
    logic       code_load = 1'b0;
    wire        ph_out;
    wire        settled;

    // golden cases
    logic [3:0] gold_code [$];
    real        gold_off  [$];

    // edge monitor state
    real last_ph0_t  = 0.0;
    real out_t       = -1.0;
    real prev_out_t  = -1.0;
    real last_offset = 0.0;
    real last_period = 0.0;
    int  out_rises   = 0;
    bit  check_pulses = 1'b0;
    int  seed        = 55;

    phase_interpolator #(.blend_delay_ps(50)) UUT (
        .ph_in     (ph_in),
        .arst_n    (arst_n),
        .pi_code   (pi_code),
        .code_load (code_load),
        .ph_out    (ph_out),
        .settled   (settled)
    );

    // four phases, 25 ns apart, 100 ns period
    initial begin
        #50;
        forever begin
            ph_in = 4'b1001;
            #25 ph_in = 4'b0011;
            #25 ph_in = 4'b0110;
            #25 ph_in = 4'b1100;
            #25;
        end
    end

    always @(posedge ph_in[0]) begin
        last_ph0_t = $realtime;
    end

    always @(posedge ph_out) begin
        prev_out_t  = out_t;
        out_t       = $realtime;
        last_offset = out_t - last_ph0_t;
        last_period = out_t - prev_out_t;
        out_rises   = out_rises + 1;
    end

    // narrow pulses in steady windows
    always @(negedge ph_out) begin
        if (check_pulses) begin
            assert ($realtime - out_t >= 40.0) else begin
                $display("ERROR pulse_width: expected >= 40.0 ns actual %0.3f ns",
                         $realtime - out_t);
                report_failure("ph_out carried a narrow pulse");
            end
        end
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic read_golden();
        int    fd;
        int    n;
        string line;
        logic [3:0] c;
        real   off;
        fd = $fopen("testbench/phase_interpolator_golden.txt", "r");
        if (fd == 0) begin
            report_failure("could not open the golden file");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%h %f", c, off);
                if (n == 2) begin
                    gold_code.push_back(c);
                    gold_off.push_back(off);
                end
            end
        end
        $fclose(fd);
        if (gold_code.size() != pi_timing_pkg::n_phases * pi_timing_pkg::steps_per_quadrant) begin
            report_failure("golden file does not hold one line per code");
        end
    endtask

    // one-cycle strobe, driven on falling edges
    task automatic issue_load(input logic [3:0] c);
        @(negedge ph_in[0]);
        pi_code   = c;
        code_load = 1'b1;
        @(negedge ph_in[0]);
        code_load = 1'b0;
    endtask

    // settled is low after the edge that follows the load,
    // then rises settle_cycles ph_in[0] edges later
    task automatic check_settle(input string name);
        int n;
        @(negedge ph_in[0]);
        assert (settled === 1'b0) else begin
            $display("ERROR %s settle_fall: expected 0 actual %b", name, settled);
            report_failure("settled did not fall after the load");
        end
        n = 0;
        while (settled !== 1'b1) begin
            @(negedge ph_in[0]);
            n++;
            if (n > 20) report_failure("timeout waiting for settled to rise");
        end
        assert (n == pi_timing_pkg::settle_cycles) else begin
            $display("ERROR %s settle: expected %0d actual %0d",
                     name, pi_timing_pkg::settle_cycles, n);
            report_failure("settle count mismatch");
        end
    endtask

    task automatic wait_out_rises(input int count);
        int start;
        int n;
        start = out_rises;
        n = 0;
        while (out_rises < start + count) begin
            @(negedge ph_in[0]);
            n++;
            if (n > count + 6) report_failure("timeout waiting for a ph_out edge");
        end
    endtask

    task automatic check_offset(input string name, input real exp_off);
        real d;
        check_pulses = 1'b1;
        wait_out_rises(2);
        wait_out_rises(2);
        d = last_offset - exp_off;
        assert (d < 0.1 && d > -0.1) else begin
            $display("ERROR %s offset: expected %0.3f actual %0.3f", name, exp_off, last_offset);
            report_failure("offset mismatch");
        end
        d = last_period - 100.0;
        assert (d < 0.1 && d > -0.1) else begin
            $display("ERROR %s period: expected 100.000 actual %0.3f", name, last_period);
            report_failure("period mismatch");
        end
    endtask

    initial begin
        int idx;
        int n;
        read_golden();

        // reset and the first settle of the reset code
        repeat (10) begin
            @(negedge ph_in[0]);
            assert (ph_out === 1'b0 && settled === 1'b0) else begin
                $display("ERROR reset: expected 0/0 actual %b/%b", ph_out, settled);
                report_failure("outputs active during reset");
            end
        end
        arst_n = 1'b1;
        n = 0;
        while (settled !== 1'b1) begin
            @(negedge ph_in[0]);
            n++;
            if (n > 20) report_failure("timeout waiting for the reset code to settle");
            if (settled !== 1'b1) begin
                assert (ph_out === 1'b0) else begin
                    $display("ERROR reset_settle: expected 0 actual %b", ph_out);
                    report_failure("ph_out active before settling");
                end
            end
        end

        // golden cases in file order
        foreach (gold_code[i]) begin
            check_pulses = 1'b0;
            issue_load(gold_code[i]);
            check_settle($sformatf("golden_%0d", i));
            check_offset($sformatf("golden_%0d", i), gold_off[i]);
        end

        // random order, some loads land while settling
        for (int r = 0; r < 12; r++) begin
            check_pulses = 1'b0;
            idx = $unsigned($random(seed)) % gold_code.size();
            if ($random(seed) & 1) begin
                issue_load(gold_code[($unsigned($random(seed)) % gold_code.size())]);
                @(negedge ph_in[0]);
            end
            issue_load(gold_code[idx]);
            check_settle($sformatf("random_%0d", r));
            check_offset($sformatf("random_%0d", r), gold_off[idx]);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
